/* Makefile */
# Verilator build and run of the data cache subsystem testbench

BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module tb_dcache_subsys -f all.f -Mdir $(BUILD_DIR) -o sim
	./$(BUILD_DIR)/sim | tee $(LOG)
	@if grep -q "tests failed" $(LOG) || ! grep -q "all tests passed" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; \
		exit 1; \
	else \
		echo "simulation PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
+incdir+verif
hdl/cpu_pkg.sv
hdl/mem_pkg.sv
hdl/load_extend.sv
hdl/data_cache.sv
hdl/line_memory.sv
hdl/dcache_subsys.sv
verif/tb_dcache_subsys.sv

/* hdl/cpu_pkg.sv */
package cpu_pkg;

    // access size code as seen on the cpu port
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2,
        // completes at once and touches nothing
        SIZE_NONE = 2'd3
    } access_size_e;

    // one load or store from the core
    typedef struct packed {
        logic         write;
        access_size_e size;
        // only the load extender looks at this
        logic         is_unsigned;
        logic [31:0]  addr;
        // byte and half values sit in the low bits
        logic [31:0]  wdata;
    } cpu_req_t;

    // load result after sign or zero extension
    typedef struct packed {
        logic [31:0] rdata;
    } cpu_rsp_t;

endpackage

/* hdl/data_cache.sv */
`timescale 1ns/1ns

module data_cache #(
    parameter int NUM_SETS = 128
) (
    input  logic              clk,
    input  logic              rst,

    input  logic              req_valid,
    input  cpu_pkg::cpu_req_t req,
    output logic              req_ready,
    output logic [31:0]       raw_data,

    output mem_pkg::mem_req_t mem_req,
    input  logic              mem_ready,
    input  mem_pkg::line_t    mem_rdata
);

    localparam int INDEX_BITS = $clog2(NUM_SETS);
    localparam int TAG_BITS   = 32 - INDEX_BITS - mem_pkg::OFFSET_BITS;

    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        ALLOCATE,
        INSTALL
    } state_t;

    state_t state, next_state;

    // per set control bits for two ways
    logic [NUM_SETS-1:0][1:0] valid_q;
    logic [NUM_SETS-1:0][1:0] dirty_q;
    // way to replace next
    logic [NUM_SETS-1:0]      lru_q;

    logic [TAG_BITS-1:0]      tag_q  [NUM_SETS][2];
    mem_pkg::line_t           data_q [NUM_SETS][2];

    // request held across a miss plus the chosen victim way
    cpu_pkg::cpu_req_t        cap_req;
    logic                     cap_way;
    mem_pkg::line_t           fill_q;

    logic [INDEX_BITS-1:0]    index;
    logic [TAG_BITS-1:0]      tag;
    logic [mem_pkg::OFFSET_BITS-1:0] byte_off;
    logic [INDEX_BITS-1:0]    cap_index;
    logic [TAG_BITS-1:0]      cap_tag;

    logic                     hit0;
    logic                     hit1;
    logic                     hit_way;
    logic                     access;
    logic                     hit;
    logic                     miss;
    logic                     victim_dirty;
    mem_pkg::line_t           hit_line;
    logic [31:0]              word_sel;

    assign index     = req.addr[mem_pkg::OFFSET_BITS +: INDEX_BITS];
    assign tag       = req.addr[31 -: TAG_BITS];
    assign byte_off  = req.addr[mem_pkg::OFFSET_BITS-1:0];
    assign cap_index = cap_req.addr[mem_pkg::OFFSET_BITS +: INDEX_BITS];
    assign cap_tag   = cap_req.addr[31 -: TAG_BITS];

    // lookup of both ways in the indexed set
    assign hit0    = valid_q[index][0] && (tag_q[index][0] == tag);
    assign hit1    = valid_q[index][1] && (tag_q[index][1] == tag);
    assign hit_way = hit1 && !hit0;

    assign access = req_valid && (req.size != cpu_pkg::SIZE_NONE);
    assign hit    = access && (hit0 || hit1);
    assign miss   = access && !(hit0 || hit1);

    assign victim_dirty = valid_q[index][lru_q[index]] && dirty_q[index][lru_q[index]];

    // not-stall that is also high for idle cycles and no-access codes
    assign req_ready = (state == IDLE) && !miss;

    // store data lands in the line at its byte position
    function automatic mem_pkg::line_t merge_store(
        input mem_pkg::line_t    line,
        input cpu_pkg::cpu_req_t r
    );
        mem_pkg::line_t                  merged;
        logic [mem_pkg::OFFSET_BITS-1:0] off;
        merged = line;
        off    = r.addr[mem_pkg::OFFSET_BITS-1:0];
        case (r.size)
            cpu_pkg::SIZE_BYTE: merged[{off, 3'b000} +: 8]  = r.wdata[7:0];
            cpu_pkg::SIZE_HALF: merged[{off, 3'b000} +: 16] = r.wdata[15:0];
            cpu_pkg::SIZE_WORD: merged[{off, 3'b000} +: 32] = r.wdata;
            default: ;
        endcase
        return merged;
    endfunction

    // zero-extended read path
    assign hit_line = hit_way ? data_q[index][1] : data_q[index][0];
    assign word_sel = hit_line[{byte_off[mem_pkg::OFFSET_BITS-1:2], 5'b00000} +: 32];

    always_comb begin
        case (req.size)
            cpu_pkg::SIZE_BYTE: raw_data = {24'b0, word_sel[{byte_off[1:0], 3'b000} +: 8]};
            cpu_pkg::SIZE_HALF: raw_data = {16'b0, word_sel[{byte_off[1], 4'b0000} +: 16]};
            default:            raw_data = word_sel;
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (miss) begin
                    next_state = victim_dirty ? WRITEBACK : ALLOCATE;
                end
            end
            WRITEBACK: begin
                if (mem_ready) begin
                    next_state = ALLOCATE;
                end
            end
            ALLOCATE: begin
                if (mem_ready) begin
                    next_state = INSTALL;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    // memory side works only from the captured request
    always_comb begin
        mem_req = '0;
        case (state)
            WRITEBACK: begin
                mem_req.write = 1'b1;
                mem_req.addr  = {tag_q[cap_index][cap_way], cap_index,
                                 {mem_pkg::OFFSET_BITS{1'b0}}};
                mem_req.wdata = data_q[cap_index][cap_way];
            end
            ALLOCATE: begin
                mem_req.read = 1'b1;
                mem_req.addr = {cap_tag, cap_index, {mem_pkg::OFFSET_BITS{1'b0}}};
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            cap_req <= '0;
            cap_way <= 1'b0;
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            state <= next_state;
            if (state == IDLE && miss) begin
                cap_req <= req;
                cap_way <= lru_q[index];
            end
            if (state == IDLE && hit) begin
                lru_q[index] <= ~hit_way;
                if (req.write) begin
                    dirty_q[index][hit_way] <= 1'b1;
                end
            end
            if (state == INSTALL) begin
                valid_q[cap_index][cap_way] <= 1'b1;
                dirty_q[cap_index][cap_way] <= cap_req.write;
                lru_q[cap_index]            <= ~cap_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == ALLOCATE && mem_ready) begin
            fill_q <= mem_rdata;
        end
        if (state == INSTALL) begin
            tag_q[cap_index][cap_way]  <= cap_tag;
            // write miss merges the store into the fetched line
            data_q[cap_index][cap_way] <= cap_req.write ? merge_store(fill_q, cap_req) : fill_q;
        end else if (state == IDLE && hit && req.write) begin
            data_q[index][hit_way] <= merge_store(hit_line, req);
        end
    end

    a_mem_rw_excl: assert property (@(posedge clk) disable iff (rst)
        !(mem_req.read && mem_req.write))
        else $error("memory read and write requested together");

    a_mem_aligned: assert property (@(posedge clk) disable iff (rst)
        (mem_req.read || mem_req.write) |-> (mem_req.addr[mem_pkg::OFFSET_BITS-1:0] == '0))
        else $error("memory address not line aligned");

    // the missed request stays on the port until it completes in IDLE
    a_cap_stable: assert property (@(posedge clk) disable iff (rst)
        (state != IDLE) |-> (req_valid && (req == cap_req)))
        else $error("captured request differs from the held request during a miss");

endmodule

/* hdl/dcache_subsys.sv */
`timescale 1ns/1ns

module dcache_subsys #(
    parameter int NUM_SETS    = 128,
    parameter int MEM_LATENCY = 3,
    parameter int MEM_LINES   = 1024
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid,
    input  cpu_pkg::cpu_req_t req,
    output logic              req_ready,
    output cpu_pkg::cpu_rsp_t rsp
);

    logic [31:0]       raw_data;
    mem_pkg::mem_req_t mem_req;
    logic              mem_ready;
    mem_pkg::line_t    mem_rdata;

    data_cache #(
        .NUM_SETS (NUM_SETS)
    ) u_data_cache (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .raw_data  (raw_data),
        .mem_req   (mem_req),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata)
    );

    // extension sits after the cache on the load path
    load_extend u_load_extend (
        .raw_data    (raw_data),
        .size        (req.size),
        .is_unsigned (req.is_unsigned),
        .rsp         (rsp)
    );

    line_memory #(
        .MEM_LATENCY (MEM_LATENCY),
        .MEM_LINES   (MEM_LINES)
    ) u_line_memory (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata)
    );

endmodule

/* hdl/line_memory.sv */
`timescale 1ns/1ns

module line_memory #(
    parameter int MEM_LATENCY = 3,
    parameter int MEM_LINES   = 1024
) (
    input  logic              clk,
    input  logic              rst,
    input  mem_pkg::mem_req_t mem_req,
    output logic              mem_ready,
    output mem_pkg::line_t    mem_rdata
);

    localparam int IDX_BITS = $clog2(MEM_LINES);
    localparam int CNT_BITS = $clog2(MEM_LATENCY) + 1;

    mem_pkg::line_t      mem_q [MEM_LINES];
    logic [CNT_BITS-1:0] cnt_q;
    logic                active;
    logic [IDX_BITS-1:0] line_idx;

    assign active = mem_req.read || mem_req.write;

    // upper address bits are dropped, so addresses wrap
    assign line_idx = mem_req.addr[mem_pkg::OFFSET_BITS +: IDX_BITS];

    // ready in the last cycle of the latency window
    assign mem_ready = active && (cnt_q == CNT_BITS'(MEM_LATENCY - 1));
    assign mem_rdata = mem_q[line_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_q <= '0;
        end else if (!active || mem_ready) begin
            // restart for the next request
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < MEM_LINES; i++) begin
                mem_q[i] <= '0;
            end
        end else if (mem_ready && mem_req.write) begin
            mem_q[line_idx] <= mem_req.wdata;
        end
    end

    // cache must hold the request until mem_ready
    a_addr_held: assert property (@(posedge clk) disable iff (rst)
        (cnt_q != '0) |-> (active && $stable(mem_req.addr)))
        else $error("memory request dropped or moved while pending");

endmodule

/* hdl/load_extend.sv */
`timescale 1ns/1ns

module load_extend (
    input  logic                  [31:0] raw_data,
    input  cpu_pkg::access_size_e        size,
    input  logic                         is_unsigned,
    output cpu_pkg::cpu_rsp_t            rsp
);

    logic byte_sign;
    logic half_sign;

    // sign source bits, forced low for unsigned loads
    assign byte_sign = raw_data[7] && !is_unsigned;
    assign half_sign = raw_data[15] && !is_unsigned;

    always_comb begin
        case (size)
            cpu_pkg::SIZE_BYTE: begin
                rsp.rdata = {{24{byte_sign}}, raw_data[7:0]};
            end
            cpu_pkg::SIZE_HALF: begin
                rsp.rdata = {{16{half_sign}}, raw_data[15:0]};
            end
            // word and no-access pass through
            default: begin
                rsp.rdata = raw_data;
            end
        endcase
    end

endmodule

/* hdl/mem_pkg.sv */
package mem_pkg;

    // one cache line, also the width of the memory bus
    localparam int LINE_BITS = 128;

    // byte offset bits inside a line
    localparam int OFFSET_BITS = 4;

    typedef logic [LINE_BITS-1:0] line_t;

    // line-wide request towards the backing memory
    // read or write is held as a level until mem_ready
    typedef struct packed {
        logic        read;
        logic        write;
        // always line aligned
        logic [31:0] addr;
        line_t       wdata;
    } mem_req_t;

endpackage

/* verif/dcache_model.svh */
`ifndef DCACHE_MODEL_SVH
`define DCACHE_MODEL_SVH

// flat byte image of what the whole hierarchy should hold, cache and memory together
logic [7:0] ref_mem [MEM_BYTES];

// addresses wrap like the backing memory does
function automatic int unsigned wrap_addr(input logic [31:0] addr);
    return addr % MEM_BYTES;
endfunction

function automatic int unsigned size_bytes(input cpu_pkg::access_size_e size);
    case (size)
        cpu_pkg::SIZE_BYTE: return 1;
        cpu_pkg::SIZE_HALF: return 2;
        cpu_pkg::SIZE_WORD: return 4;
        default:            return 0;
    endcase
endfunction

function automatic void clear_reference();
    for (int i = 0; i < MEM_BYTES; i++) begin
        ref_mem[i] = 8'h00;
    end
endfunction

// little endian, low bits of wdata go to the lowest address
function automatic void apply_store(input logic [31:0] addr,
                                    input cpu_pkg::access_size_e size,
                                    input logic [31:0] wdata);
    int n;
    n = size_bytes(size);
    for (int i = 0; i < n; i++) begin
        ref_mem[wrap_addr(addr + i)] = wdata[8*i +: 8];
    end
endfunction

// expected load result after sign or zero extension
function automatic logic [31:0] predict_load(input logic [31:0] addr,
                                             input cpu_pkg::access_size_e size,
                                             input logic is_unsigned);
    logic [31:0] value;
    int          n;
    value = '0;
    n     = size_bytes(size);
    for (int i = 0; i < n; i++) begin
        value[8*i +: 8] = ref_mem[wrap_addr(addr + i)];
    end
    if (size == cpu_pkg::SIZE_BYTE && !is_unsigned && value[7]) begin
        value[31:8] = '1;
    end
    if (size == cpu_pkg::SIZE_HALF && !is_unsigned && value[15]) begin
        value[31:16] = '1;
    end
    return value;
endfunction

`endif

/* verif/tb_dcache_subsys.sv */
`timescale 1ns/1ns

module tb_dcache_subsys;

    localparam int          NUM_SETS       = 128;
    localparam int          MEM_LATENCY    = 3;
    localparam int          MEM_LINES      = 1024;
    localparam int unsigned MEM_BYTES      = MEM_LINES * 16;
    // distance between two addresses that share a set
    localparam int unsigned SET_STRIDE     = NUM_SETS * 16;
    localparam int unsigned NUM_TAGS       = MEM_BYTES / SET_STRIDE;
    localparam int          TIMEOUT_CYCLES = 100;

    logic              clk;
    logic              rst;
    logic              req_valid;
    cpu_pkg::cpu_req_t req;
    logic              req_ready;
    cpu_pkg::cpu_rsp_t rsp;

    int err_count;
    int tests_run;
    int tests_bad;

    `include "dcache_model.svh"

    dcache_subsys #(
        .NUM_SETS    (NUM_SETS),
        .MEM_LATENCY (MEM_LATENCY),
        .MEM_LINES   (MEM_LINES)
    ) u_dcache_subsys (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp       (rsp)
    );

    always begin
        #5 clk = ~clk;
    end

    function automatic cpu_pkg::cpu_req_t build_request(input logic write,
                                                        input cpu_pkg::access_size_e size,
                                                        input logic is_unsigned,
                                                        input logic [31:0] addr,
                                                        input logic [31:0] wdata);
        cpu_pkg::cpu_req_t r;
        r.write       = write;
        r.size        = size;
        r.is_unsigned = is_unsigned;
        r.addr        = addr;
        r.wdata       = wdata;
        return r;
    endfunction

    function automatic cpu_pkg::access_size_e pick_size();
        int unsigned r;
        r = $urandom % 3;
        case (r)
            0:       return cpu_pkg::SIZE_BYTE;
            1:       return cpu_pkg::SIZE_HALF;
            default: return cpu_pkg::SIZE_WORD;
        endcase
    endfunction

    // random address inside the memory, aligned to the access size
    function automatic logic [31:0] pick_addr(input cpu_pkg::access_size_e size);
        logic [31:0] a;
        a = $urandom % MEM_BYTES;
        if (size == cpu_pkg::SIZE_HALF) begin
            a[0] = 1'b0;
        end else if (size == cpu_pkg::SIZE_WORD) begin
            a[1:0] = 2'b00;
        end
        return a;
    endfunction

    // called 1 ns after a rising edge, returns at the same point of a later cycle
    task automatic issue_request(input cpu_pkg::cpu_req_t r, output logic [31:0] data,
                                 output logic done);
        int cycles;
        cycles    = 0;
        done      = 1'b0;
        data      = '0;
        req       = r;
        req_valid = 1'b1;
        while (!done && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            if (req_ready) begin
                done = 1'b1;
                data = rsp.rdata;
            end
            cycles++;
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        assert (done) else begin
            $display("request to address %h never completed within %0d cycles",
                     r.addr, TIMEOUT_CYCLES);
            err_count++;
        end
    endtask

    task automatic store_value(input logic [31:0] addr, input cpu_pkg::access_size_e size,
                               input logic [31:0] wdata);
        logic [31:0] unused;
        logic        done;
        issue_request(build_request(1'b1, size, 1'b0, addr, wdata), unused, done);
        apply_store(addr, size, wdata);
    endtask

    task automatic load_and_compare(input logic [31:0] addr, input cpu_pkg::access_size_e size,
                                    input logic is_unsigned);
        logic [31:0] expected;
        logic [31:0] got;
        logic        done;
        expected = predict_load(addr, size, is_unsigned);
        issue_request(build_request(1'b0, size, is_unsigned, addr, 32'h0), got, done);
        if (done) begin
            assert (got === expected) else begin
                $display("mismatch at %0t: addr %h size %0d unsigned %0b expected %h got %h",
                         $time, addr, size, is_unsigned, expected, got);
                err_count++;
            end
        end
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        tests_run++;
        if (err_count == errs_at_start) begin
            $display("test %s: pass", name);
        end else begin
            tests_bad++;
            $display("test %s: FAIL with %0d errors", name, err_count - errs_at_start);
        end
    endtask

    task automatic zero_fill_loads();
        int start;
        start = err_count;
        repeat (200) begin
            load_and_compare(pick_addr(cpu_pkg::SIZE_WORD), cpu_pkg::SIZE_WORD, 1'b0);
        end
        finish_test("zero_fill_loads", start);
    endtask

    task automatic store_then_load();
        int                    start;
        cpu_pkg::access_size_e size;
        logic [31:0]           addr;
        start = err_count;
        repeat (300) begin
            size = pick_size();
            addr = pick_addr(size);
            store_value(addr, size, $urandom);
            load_and_compare(addr, size, 1'($urandom % 2));
        end
        finish_test("store_then_load", start);
    endtask

    // every tag of one set in turn, so most accesses evict a dirty line
    task automatic set_conflicts();
        int          start;
        int unsigned set;
        logic [31:0] addrs [$];
        start = err_count;
        repeat (6) begin
            set = $urandom % NUM_SETS;
            addrs.delete();
            for (int t = 0; t < NUM_TAGS; t++) begin
                addrs.push_back(t * SET_STRIDE + set * 16 + ($urandom % 4) * 4);
                store_value(addrs[t], cpu_pkg::SIZE_WORD, $urandom);
            end
            for (int t = NUM_TAGS - 1; t >= 0; t--) begin
                load_and_compare(addrs[t], cpu_pkg::SIZE_WORD, 1'b0);
            end
        end
        finish_test("set_conflicts", start);
    endtask

    task automatic random_traffic();
        int                    start;
        int unsigned           kind;
        cpu_pkg::access_size_e size;
        logic [31:0]           addr;
        logic [31:0]           unused;
        logic                  done;
        start = err_count;
        repeat (2000) begin
            kind = $urandom % 8;
            size = pick_size();
            addr = pick_addr(size);
            // half the traffic stays in a small window to get hits
            if ($urandom % 2 == 0) begin
                addr = addr % SET_STRIDE;
            end
            if (kind == 0) begin
                issue_request(build_request(1'b1, cpu_pkg::SIZE_NONE, 1'b0, addr, $urandom),
                              unused, done);
            end else if (kind < 4) begin
                store_value(addr, size, $urandom);
            end else begin
                load_and_compare(addr, size, 1'($urandom % 2));
            end
        end
        finish_test("random_traffic", start);
    endtask

    task automatic no_access_requests();
        int          start;
        logic [31:0] addr;
        logic [31:0] unused;
        logic        done;
        start = err_count;
        repeat (100) begin
            addr = pick_addr(cpu_pkg::SIZE_WORD);
            store_value(addr, cpu_pkg::SIZE_WORD, $urandom);
            // a write flag with the no-access code must leave the word alone
            issue_request(build_request(1'b1, cpu_pkg::SIZE_NONE, 1'b0, addr, $urandom),
                          unused, done);
            load_and_compare(addr, cpu_pkg::SIZE_WORD, 1'b0);
        end
        finish_test("no_access_requests", start);
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        err_count = 0;
        tests_run = 0;
        tests_bad = 0;
        void'($urandom(21991));
        clear_reference();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;
        zero_fill_loads();
        store_then_load();
        set_conflicts();
        random_traffic();
        no_access_requests();
        $display("summary: %0d run, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_bad, tests_bad, err_count);
        if (tests_bad == 0 && err_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
